/* sim/s1c88_tb.sv */
`timescale 1ns/1ps

module s1c88_tb
    import s1c88_pkg::*;
();

    localparam word_t VECTOR = 16'h0000;
    localparam int RANDOM_COUNT = 200;

    logic clk;
    logic reset;
    byte_t data_in;
    byte_t data_out;
    word_t address_out;
    logic read;
    logic write;
    logic sync;
    logic pk;
    logic pl;

    byte_t mem [0:65535];
    byte_t ref_mem [0:65535];
    word_t exp_syncs [$];
    logic [23:0] exp_writes [$];
    string test_name = "startup";
    word_t build_ptr;
    int instr_count;
    int sync_seen = 0;
    int write_seen = 0;
    int reads_seen = 0;
    logic phase_seen = 1'b0;
    logic prev_pk = 1'b0;

    s1c88 #(.STARTUP_CYCLES(2), .VECTOR_ADDRESS(VECTOR)) s1c88_inst (.*);

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped in test %s", test_name);
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
        input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("error: test %s, %s: expected %0h, actual %0h",
                test_name, what, expected, actual);
            stop_with_failure("a DUT output differs from the reference model");
        end
    endtask

    // memory answers in the middle of the cycle, writes land during the pl half
    always @(negedge clk)
    begin
        if (write)
            mem[address_out] = data_out;
        data_in = mem[address_out];
    end

    // bus form, vector reads, sync addresses and the write stream, all sampled mid-cycle
    always @(negedge clk)
    begin
        if (reset)
        begin
            sync_seen = 0;
            write_seen = 0;
            reads_seen = 0;
            phase_seen = 1'b0;
        end
        else
        begin
            check_equal("pk and pl both high", 0, pk && pl);
            check_equal("read and write both high", 0, read && write);
            check_equal("write outside the pl half", 0, write && !pl);
            if (phase_seen)
            begin
                check_equal("pk toggle", !prev_pk, pk);
                check_equal("pl opposite pk", !pk, pl);
            end
            if (pk)
                phase_seen = 1'b1;
            prev_pk = pk;
            if (read && pk && reads_seen < 2)
            begin
                check_equal("vector read address", VECTOR + reads_seen, address_out);
                reads_seen++;
            end
            if (sync && pk && sync_seen < exp_syncs.size())
            begin
                check_equal($sformatf("sync %0d address", sync_seen),
                    exp_syncs[sync_seen], address_out);
                sync_seen++;
            end
            if (write && sync_seen < exp_syncs.size())
            begin
                if (write_seen >= exp_writes.size())
                    stop_with_failure("the DUT wrote more bytes than the reference model");
                check_equal($sformatf("write %0d address", write_seen),
                    exp_writes[write_seen][23:8], address_out);
                check_equal($sformatf("write %0d data", write_seen),
                    exp_writes[write_seen][7:0], data_out);
                write_seen++;
            end
        end
    end

    function automatic void reference_store(input word_t address, input byte_t value);
        ref_mem[address] = value;
        exp_writes.push_back({address, value});
    endfunction

    // runs count instructions on a copy of the image and lists syncs and writes
    function automatic void run_reference(input int count);
        word_t pc;
        word_t hl;
        word_t sp;
        word_t imm;
        byte_t a;
        byte_t b;
        byte_t op;
        int n;
        ref_mem = mem;
        exp_syncs.delete();
        exp_writes.delete();
        a = 8'h00;
        b = 8'h00;
        hl = 16'h0000;
        sp = 16'h0000;
        pc = {ref_mem[VECTOR + 16'd1], ref_mem[VECTOR]};
        for (n = 0; n < count; n++)
        begin
            exp_syncs.push_back(pc);
            op = ref_mem[pc];
            pc = pc + 16'd1;
            imm = 16'h0000;
            if (op inside {8'hB0, 8'hB1, 8'h02, 8'h12, 8'h22, 8'h32})
            begin
                imm[7:0] = ref_mem[pc];
                pc = pc + 16'd1;
            end
            else if (op inside {8'hC4, 8'hC5, 8'hF2, 8'hDD})
            begin
                imm[7:0] = ref_mem[pc];
                imm[15:8] = ref_mem[pc + 16'd1];
                pc = pc + 16'd2;
            end
            case (op)
                8'hB0: a = imm[7:0];
                8'hB1: b = imm[7:0];
                8'hC4: hl = imm;
                8'hC5: sp = imm;
                8'h02: a = a + imm[7:0];
                8'h12: a = a - imm[7:0];
                8'h22: a = a & imm[7:0];
                8'h32: a = a | imm[7:0];
                8'h78: reference_store(hl, a);
                8'h58: a = ref_mem[hl];
                8'h92: hl = hl + 16'd1;
                8'hA8:
                begin
                    reference_store(sp - 16'd1, b);
                    reference_store(sp - 16'd2, a);
                    sp = sp - 16'd2;
                end
                8'hAC:
                begin
                    a = ref_mem[sp];
                    b = ref_mem[sp + 16'd1];
                    sp = sp + 16'd2;
                end
                8'hF2: pc = imm;
                8'hDD: reference_store(imm, a);
                default: ;
            endcase
        end
        // the following sync closes the last instruction
        exp_syncs.push_back(pc);
    endfunction

    task automatic put_byte(input byte_t value);
        mem[build_ptr] = value;
        build_ptr = build_ptr + 16'd1;
    endtask

    task automatic put_op(input opcode_t op);
        put_byte(op);
        instr_count++;
    endtask

    task automatic put_op_byte(input opcode_t op, input byte_t value);
        put_op(op);
        put_byte(value);
    endtask

    task automatic put_op_word(input opcode_t op, input word_t value);
        put_op(op);
        put_byte(value[7:0]);
        put_byte(value[15:8]);
    endtask

    task automatic put_random_instruction();
        int unsigned choice;
        word_t value;
        choice = $urandom % 15;
        value = word_t'($urandom);
        case (choice)
            0: put_op_byte(OP_LD_A_IMM, value[7:0]);
            1: put_op_byte(OP_LD_B_IMM, value[7:0]);
            2: put_op_byte(OP_ADD, value[7:0]);
            3: put_op_byte(OP_SUB, value[7:0]);
            4: put_op_byte(OP_AND, value[7:0]);
            5: put_op_byte(OP_OR, value[7:0]);
            // data and stack stay in the upper half, well clear of the program
            6: put_op_word(OP_LD_HL_IMM, {1'b1, value[14:0]});
            7: put_op_word(OP_LD_SP_IMM, {4'hC, value[11:0]});
            8: put_op_word(OP_STORE_ABS, {1'b1, value[14:0]});
            9: put_op(OP_LOAD_HL);
            10: put_op(OP_INC_HL);
            11: put_op(OP_PUSH_BA);
            12: put_op(OP_POP_BA);
            13: put_op(OP_STORE_HL);
            default: put_op(OP_NOP);
        endcase
    endtask

    task automatic begin_test(input string name, input word_t origin);
        int i;
        @(negedge clk);
        reset = 1'b1;
        // the checker sees reset at the next edge, before the image changes
        @(negedge clk);
        test_name = name;
        for (i = 0; i < 65536; i++)
            mem[i] = byte_t'(i[15:8] ^ i[7:0] ^ 8'h3C);
        mem[VECTOR] = origin[7:0];
        mem[VECTOR + 16'd1] = origin[15:8];
        build_ptr = origin;
        instr_count = 0;
    endtask

    task automatic finish_test();
        int cycles;
        int limit;
        run_reference(instr_count);
        limit = 12 * instr_count + 50;
        cycles = 0;
        @(negedge clk);
        reset = 1'b0;
        while (sync_seen < exp_syncs.size())
        begin
            @(posedge clk);
            cycles++;
            if (cycles > limit)
                stop_with_failure($sformatf(
                    "timeout: only %0d of %0d fetches seen in %0d cycles",
                    sync_seen, exp_syncs.size(), limit));
        end
        check_equal("write count", exp_writes.size(), write_seen);
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        data_in = 8'h00;
        void'($urandom(95989));

        begin_test("load_alu_store", 16'h0100);
        put_op_byte(OP_LD_A_IMM, 8'h5A);
        put_op_byte(OP_ADD, 8'hC3);
        put_op_word(OP_LD_HL_IMM, 16'h8000);
        put_op(OP_STORE_HL);
        put_op_byte(OP_SUB, 8'h71);
        put_op(OP_INC_HL);
        put_op(OP_STORE_HL);
        put_op_byte(OP_AND, 8'hF6);
        put_op_byte(OP_OR, 8'h09);
        put_op_word(OP_STORE_ABS, 16'h9123);
        put_op(OP_LOAD_HL);
        put_op_word(OP_STORE_ABS, 16'h9124);
        finish_test();

        begin_test("stack", 16'h0100);
        put_op_word(OP_LD_SP_IMM, 16'hA000);
        put_op_byte(OP_LD_A_IMM, 8'h3C);
        put_op_byte(OP_LD_B_IMM, 8'hC3);
        put_op(OP_PUSH_BA);
        put_op_byte(OP_LD_A_IMM, 8'h00);
        put_op_word(OP_LD_HL_IMM, 16'h8200);
        put_op(OP_POP_BA);
        put_op(OP_STORE_HL);
        finish_test();

        // jumps hop over background bytes, two undefined opcodes run as single bytes
        begin_test("control_flow", 16'h0240);
        put_op(OP_NOP);
        put_op_word(OP_JP, 16'h0300);
        build_ptr = 16'h0300;
        put_op(OP_NOP);
        put_op(8'h00);
        put_op(8'h5F);
        put_op_word(OP_JP, 16'h0250);
        build_ptr = 16'h0250;
        put_op_byte(OP_LD_A_IMM, 8'h77);
        put_op(OP_STORE_HL);
        finish_test();

        begin_test("random", 16'h0100);
        repeat (RANDOM_COUNT)
        begin
            put_random_instruction();
            put_op(OP_STORE_HL);
        end
        finish_test();

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu
    import s1c88_pkg::*;
(
    input alu_op_t alu_op,
    input byte_t a,
    input byte_t b,
    output byte_t result
);

    // results wrap at eight bits, there are no flags in this core
    always_comb
    begin
        case (alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR: result = a | b;
            default: result = b;
        endcase
    end

endmodule

/* src/bus_phase.sv */
`timescale 1ns/1ps

module bus_phase
#(
    parameter int STARTUP_CYCLES = 2
)
(
    input logic clk,
    input logic reset,
    output logic run,
    output logic pk,
    output logic pl
);

    logic [$clog2(STARTUP_CYCLES + 1) - 1:0] count;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            count <= '0;
            run <= 1'b0;
            pk <= 1'b0;
            pl <= 1'b0;
        end
        else if (!run)
        begin
            // the first bus cycle opens with pk as soon as the delay runs out
            if (count == STARTUP_CYCLES - 1)
            begin
                run <= 1'b1;
                pk <= 1'b1;
            end
            else
                count <= count + 1'b1;
        end
        else
        begin
            pk <= ~pk;
            pl <= pk;
        end
    end

    a_phases_differ: assert property (@(posedge clk) disable iff (reset) run |-> pk != pl);

endmodule

/* src/bus_sequencer.sv */
`timescale 1ns/1ps

module bus_sequencer
    import s1c88_pkg::*;
#(
    parameter word_t VECTOR_ADDRESS = 16'h0000
)
(
    input logic clk,
    input logic reset,
    input logic run,
    input logic pk,
    input logic need_imm,
    input logic imm_size,
    input logic last,
    input micro_addr_t micro_entry,
    input bus_op_t bus_op,
    input addr_src_t addr_src,
    input mov_dst_t mov_dst,
    input word_t ba,
    input word_t hl,
    input word_t sp,
    input word_t move_data,
    input byte_t data_in,
    output micro_addr_t micro_addr,
    output opcode_t opcode,
    output word_t imm,
    output logic step,
    output logic sp_dec,
    output logic sp_inc,
    output word_t address_out,
    output byte_t data_out,
    output logic read,
    output logic write,
    output logic sync
);

    seq_state_t state;
    seq_state_t next_state;
    word_t pc;
    word_t bus_address;
    micro_addr_t micro_ptr;
    logic micro_done;
    logic write_cycle;
    logic bus_write;
    logic cycle_start;
    logic cycle_end;
    logic pc_load;

    // a bus cycle starts at the edge where pk rises and ends where pl rises
    assign cycle_start = run && !pk;
    assign cycle_end = run && pk;

    always_comb
    begin
        case (state)
            IDLE: next_state = VECTOR_LOW;
            VECTOR_LOW: next_state = VECTOR_HIGH;
            VECTOR_HIGH: next_state = FETCH;
            FETCH: next_state = need_imm ? IMM_LOW : EXECUTE;
            IMM_LOW: next_state = imm_size ? IMM_HIGH : EXECUTE;
            IMM_HIGH: next_state = EXECUTE;
            EXECUTE: next_state = micro_done ? FETCH : EXECUTE;
            default: next_state = IDLE;
        endcase
    end

    always_comb
    begin
        case (addr_src)
            ADDR_SP_PUSH: bus_address = sp - 16'd1;
            ADDR_SP_POP: bus_address = sp;
            ADDR_IMM: bus_address = imm;
            default: bus_address = hl;
        endcase
    end

    // the first micro step is addressed straight from the decoder
    assign micro_addr = (state == EXECUTE) ? micro_ptr : micro_entry;

    assign bus_write = (next_state == EXECUTE) && (bus_op == BUS_WRITE);
    assign step = cycle_end && (state == EXECUTE);
    assign pc_load = step && (mov_dst == DST_PC);
    assign sp_dec = cycle_start && bus_write && (addr_src == ADDR_SP_PUSH);
    assign sp_inc = step && (bus_op == BUS_READ) && (addr_src == ADDR_SP_POP);
    assign write = write_cycle && !pk;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= IDLE;
            pc <= '0;
            opcode <= OP_NOP;
            micro_ptr <= ENTRY_NOP;
            micro_done <= 1'b0;
            address_out <= '1;
            data_out <= '1;
            read <= 1'b0;
            write_cycle <= 1'b0;
            sync <= 1'b0;
        end
        else if (cycle_start)
        begin
            state <= next_state;
            read <= (next_state != EXECUTE) || (bus_op == BUS_READ);
            write_cycle <= bus_write;
            sync <= (next_state == FETCH);
            case (next_state)
                VECTOR_LOW: address_out <= VECTOR_ADDRESS;
                VECTOR_HIGH: address_out <= VECTOR_ADDRESS + 16'd1;
                EXECUTE:
                begin
                    if (state != EXECUTE)
                        micro_ptr <= micro_entry;
                    if (bus_op != BUS_NONE)
                        address_out <= bus_address;
                end
                default:
                begin
                    address_out <= pc;
                    pc <= pc + 16'd1;
                end
            endcase
            // B goes out first on a push so that it lands at the higher address
            if (bus_write)
                data_out <= (addr_src == ADDR_SP_PUSH && !last) ? ba[15:8] : ba[7:0];
        end
        else if (cycle_end)
        begin
            case (state)
                VECTOR_LOW: pc[7:0] <= data_in;
                VECTOR_HIGH: pc[15:8] <= data_in;
                FETCH: opcode <= data_in;
                EXECUTE:
                begin
                    micro_done <= last;
                    if (!last)
                        micro_ptr <= micro_ptr + 5'd1;
                end
                default: ;
            endcase
            if (pc_load)
                pc <= move_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cycle_end && state == IMM_LOW)
            imm <= {8'h00, data_in};
        else if (cycle_end && state == IMM_HIGH)
            imm[15:8] <= data_in;
    end

    a_read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

endmodule

/* src/micro_rom.sv */
`timescale 1ns/1ps

module micro_rom
    import s1c88_pkg::*;
(
    input micro_addr_t micro_addr,
    output bus_op_t bus_op,
    output addr_src_t addr_src,
    output mov_src_t mov_src,
    output mov_dst_t mov_dst,
    output alu_op_t alu_op,
    output logic last
);

    // only the first steps of push and pop continue into a second step
    assign last = !(micro_addr inside {ENTRY_PUSH_B, ENTRY_POP_A});

    always_comb
    begin
        case (micro_addr)
            ENTRY_STORE_HL, ENTRY_PUSH_B, ENTRY_PUSH_A, ENTRY_STORE_ABS: bus_op = BUS_WRITE;
            ENTRY_LOAD_HL, ENTRY_POP_A, ENTRY_POP_B: bus_op = BUS_READ;
            default: bus_op = BUS_NONE;
        endcase

        case (micro_addr)
            ENTRY_PUSH_B, ENTRY_PUSH_A: addr_src = ADDR_SP_PUSH;
            ENTRY_POP_A, ENTRY_POP_B: addr_src = ADDR_SP_POP;
            ENTRY_STORE_ABS: addr_src = ADDR_IMM;
            default: addr_src = ADDR_HL;
        endcase

        case (micro_addr)
            ENTRY_LD_A_IMM, ENTRY_LD_B_IMM, ENTRY_JP: mov_src = SRC_IMM_LOW;
            ENTRY_LD_HL_IMM, ENTRY_LD_SP_IMM: mov_src = SRC_IMM_LOW;
            ENTRY_ADD, ENTRY_SUB, ENTRY_AND, ENTRY_OR: mov_src = SRC_ALU;
            ENTRY_LOAD_HL, ENTRY_POP_A, ENTRY_POP_B: mov_src = SRC_DATA_IN;
            default: mov_src = SRC_NONE;
        endcase

        case (micro_addr)
            ENTRY_LD_A_IMM, ENTRY_LOAD_HL, ENTRY_POP_A: mov_dst = DST_A;
            ENTRY_ADD, ENTRY_SUB, ENTRY_AND, ENTRY_OR: mov_dst = DST_A;
            ENTRY_LD_B_IMM, ENTRY_POP_B: mov_dst = DST_B;
            ENTRY_LD_HL_IMM: mov_dst = DST_HL;
            ENTRY_INC_HL: mov_dst = DST_HL_INC;
            ENTRY_LD_SP_IMM: mov_dst = DST_SP;
            ENTRY_JP: mov_dst = DST_PC;
            default: mov_dst = DST_NONE;
        endcase

        case (micro_addr)
            ENTRY_ADD: alu_op = ALU_ADD;
            ENTRY_SUB: alu_op = ALU_SUB;
            ENTRY_AND: alu_op = ALU_AND;
            ENTRY_OR: alu_op = ALU_OR;
            default: alu_op = ALU_PASS;
        endcase
    end

    always_comb
    begin
        a_addr_in_table: assert final ($isunknown(micro_addr) || micro_addr <= ENTRY_LAST);
    end

endmodule

/* src/opcode_decode.sv */
`timescale 1ns/1ps

module opcode_decode
    import s1c88_pkg::*;
(
    input opcode_t opcode,
    output logic need_imm,
    output logic imm_size,
    output micro_addr_t micro_entry
);

    // the 16-bit operand forms read two immediate bytes
    assign imm_size = opcode inside {OP_LD_HL_IMM, OP_LD_SP_IMM, OP_JP, OP_STORE_ABS};

    assign need_imm = imm_size ||
        (opcode inside {OP_LD_A_IMM, OP_LD_B_IMM, OP_ADD, OP_SUB, OP_AND, OP_OR});

    always_comb
    begin
        case (opcode)
            OP_LD_A_IMM: micro_entry = ENTRY_LD_A_IMM;
            OP_LD_B_IMM: micro_entry = ENTRY_LD_B_IMM;
            OP_LD_HL_IMM: micro_entry = ENTRY_LD_HL_IMM;
            OP_LD_SP_IMM: micro_entry = ENTRY_LD_SP_IMM;
            OP_ADD: micro_entry = ENTRY_ADD;
            OP_SUB: micro_entry = ENTRY_SUB;
            OP_AND: micro_entry = ENTRY_AND;
            OP_OR: micro_entry = ENTRY_OR;
            OP_STORE_HL: micro_entry = ENTRY_STORE_HL;
            OP_LOAD_HL: micro_entry = ENTRY_LOAD_HL;
            OP_INC_HL: micro_entry = ENTRY_INC_HL;
            OP_PUSH_BA: micro_entry = ENTRY_PUSH_B;
            OP_POP_BA: micro_entry = ENTRY_POP_A;
            OP_JP: micro_entry = ENTRY_JP;
            OP_STORE_ABS: micro_entry = ENTRY_STORE_ABS;
            // NOP and every undefined opcode share the empty single step
            default: micro_entry = ENTRY_NOP;
        endcase
    end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file
    import s1c88_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic step,
    input logic sp_dec,
    input logic sp_inc,
    input mov_src_t mov_src,
    input mov_dst_t mov_dst,
    input word_t imm,
    input byte_t data_in,
    input byte_t alu_result,
    output word_t ba,
    output word_t hl,
    output word_t sp,
    output word_t move_data
);

    always_comb
    begin
        case (mov_src)
            SRC_A: move_data = {8'h00, ba[7:0]};
            SRC_B: move_data = {8'h00, ba[15:8]};
            SRC_IMM_LOW: move_data = imm;
            SRC_ALU: move_data = {8'h00, alu_result};
            SRC_DATA_IN: move_data = {8'h00, data_in};
            default: move_data = '0;
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            ba <= '0;
            hl <= '0;
            sp <= '0;
        end
        else
        begin
            // push predecrements at the cycle start, pop postincrements at its end
            if (sp_dec)
                sp <= sp - 16'd1;
            else if (sp_inc)
                sp <= sp + 16'd1;

            // PC moves are taken by the sequencer
            if (step)
            begin
                case (mov_dst)
                    DST_A: ba[7:0] <= move_data[7:0];
                    DST_B: ba[15:8] <= move_data[7:0];
                    DST_HL: hl <= move_data;
                    DST_HL_INC: hl <= hl + 16'd1;
                    DST_SP: sp <= move_data;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* src/s1c88.sv */
`timescale 1ns/1ps

module s1c88
    import s1c88_pkg::*;
#(
    parameter int STARTUP_CYCLES = 2,
    parameter word_t VECTOR_ADDRESS = 16'h0000
)
(
    input logic clk,
    input logic reset,
    input byte_t data_in,
    output byte_t data_out,
    output word_t address_out,
    output logic read,
    output logic write,
    output logic sync,
    output logic pk,
    output logic pl
);

    logic run;
    logic need_imm;
    logic imm_size;
    logic last;
    logic step;
    logic sp_dec;
    logic sp_inc;
    opcode_t opcode;
    micro_addr_t micro_entry;
    micro_addr_t micro_addr;
    word_t imm;
    word_t ba;
    word_t hl;
    word_t sp;
    word_t move_data;
    byte_t alu_result;
    bus_op_t bus_op;
    addr_src_t addr_src;
    mov_src_t mov_src;
    mov_dst_t mov_dst;
    alu_op_t alu_op;

    bus_phase #(.STARTUP_CYCLES(STARTUP_CYCLES)) bus_phase_inst (.*);

    bus_sequencer #(.VECTOR_ADDRESS(VECTOR_ADDRESS)) bus_sequencer_inst (.*);

    opcode_decode opcode_decode_inst (.*);

    micro_rom micro_rom_inst (.*);

    register_file register_file_inst (.*);

    // the ALU always works on A and the low immediate byte
    alu alu_inst
    (
        .alu_op,
        .a(ba[7:0]),
        .b(imm[7:0]),
        .result(alu_result)
    );

endmodule

/* src/s1c88_pkg.sv */
package s1c88_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0] opcode_t;
    typedef logic [4:0] micro_addr_t;

    // opcodes of the reduced instruction set, anything else runs as a NOP
    localparam opcode_t OP_NOP       = 8'hFF;
    localparam opcode_t OP_LD_A_IMM  = 8'hB0;
    localparam opcode_t OP_LD_B_IMM  = 8'hB1;
    localparam opcode_t OP_LD_HL_IMM = 8'hC4;
    localparam opcode_t OP_LD_SP_IMM = 8'hC5;
    localparam opcode_t OP_ADD       = 8'h02;
    localparam opcode_t OP_SUB       = 8'h12;
    localparam opcode_t OP_AND       = 8'h22;
    localparam opcode_t OP_OR        = 8'h32;
    localparam opcode_t OP_STORE_HL  = 8'h78;
    localparam opcode_t OP_LOAD_HL   = 8'h58;
    localparam opcode_t OP_INC_HL    = 8'h92;
    localparam opcode_t OP_PUSH_BA   = 8'hA8;
    localparam opcode_t OP_POP_BA    = 8'hAC;
    localparam opcode_t OP_JP        = 8'hF2;
    localparam opcode_t OP_STORE_ABS = 8'hDD;

    // microprogram entry points, the two-step programs take two consecutive slots
    localparam micro_addr_t ENTRY_NOP       = 5'd0;
    localparam micro_addr_t ENTRY_LD_A_IMM  = 5'd1;
    localparam micro_addr_t ENTRY_LD_B_IMM  = 5'd2;
    localparam micro_addr_t ENTRY_ADD       = 5'd3;
    localparam micro_addr_t ENTRY_SUB       = 5'd4;
    localparam micro_addr_t ENTRY_AND       = 5'd5;
    localparam micro_addr_t ENTRY_OR        = 5'd6;
    localparam micro_addr_t ENTRY_STORE_HL  = 5'd7;
    localparam micro_addr_t ENTRY_LOAD_HL   = 5'd8;
    localparam micro_addr_t ENTRY_INC_HL    = 5'd9;
    localparam micro_addr_t ENTRY_PUSH_B    = 5'd10;
    localparam micro_addr_t ENTRY_PUSH_A    = 5'd11;
    localparam micro_addr_t ENTRY_POP_A     = 5'd12;
    localparam micro_addr_t ENTRY_POP_B     = 5'd13;
    localparam micro_addr_t ENTRY_JP        = 5'd14;
    localparam micro_addr_t ENTRY_STORE_ABS = 5'd15;
    localparam micro_addr_t ENTRY_LD_HL_IMM = 5'd16;
    localparam micro_addr_t ENTRY_LD_SP_IMM = 5'd17;
    localparam micro_addr_t ENTRY_LAST      = 5'd17;

    typedef enum logic [2:0]
    {
        IDLE,
        VECTOR_LOW,
        VECTOR_HIGH,
        FETCH,
        IMM_LOW,
        IMM_HIGH,
        EXECUTE
    } seq_state_t;

    typedef enum logic [2:0] {ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_t;
    typedef enum logic [1:0] {BUS_NONE, BUS_READ, BUS_WRITE} bus_op_t;
    typedef enum logic [1:0] {ADDR_HL, ADDR_SP_PUSH, ADDR_SP_POP, ADDR_IMM} addr_src_t;

    // SRC_IMM_LOW carries the whole immediate word, byte destinations keep its low byte
    typedef enum logic [2:0]
    {
        SRC_NONE, SRC_A, SRC_B, SRC_IMM_LOW, SRC_ALU, SRC_DATA_IN
    } mov_src_t;

    typedef enum logic [2:0]
    {
        DST_NONE, DST_A, DST_B, DST_HL, DST_HL_INC, DST_SP, DST_PC
    } mov_dst_t;

endpackage

/* verilog.f */
src/s1c88_pkg.sv
src/bus_phase.sv
src/opcode_decode.sv
src/micro_rom.sv
src/alu.sv
src/register_file.sv
src/bus_sequencer.sv
src/s1c88.sv
sim/s1c88_tb.sv
